//--- design/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data path widths.
  localparam int DATA_WIDTH     = 32;
  localparam int ADDR_WIDTH     = 32;
  localparam int INSTR_WIDTH    = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int NUM_REGS       = 2 ** REG_ADDR_WIDTH;
  localparam int SEL_WIDTH      = DATA_WIDTH / 8; // One select per byte.
  localparam int INSTR_BYTES    = INSTR_WIDTH / 8;
  localparam logic [ADDR_WIDTH-1:0] RESET_PC = '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction fields.
  localparam int OPCODE_LSB   = 26;
  localparam int OPCODE_WIDTH = 6;
  localparam int RS_LSB       = 21;
  localparam int RT_LSB       = 16;
  localparam int RD_LSB       = 11;
  localparam int FUNCT_LSB    = 0;
  localparam int FUNCT_WIDTH  = 6;
  localparam int IMM_LSB      = 0;
  localparam int IMM_WIDTH    = 16;

  localparam logic [OPCODE_WIDTH-1:0] OP_RTYPE = 6'h00;
  localparam logic [OPCODE_WIDTH-1:0] OP_BEQ   = 6'h04;
  localparam logic [OPCODE_WIDTH-1:0] OP_ADDI  = 6'h08;
  localparam logic [OPCODE_WIDTH-1:0] OP_LW    = 6'h23;
  localparam logic [OPCODE_WIDTH-1:0] OP_SW    = 6'h2b;

  localparam logic [FUNCT_WIDTH-1:0] FN_ADD = 6'h20;
  localparam logic [FUNCT_WIDTH-1:0] FN_SUB = 6'h22;
  localparam logic [FUNCT_WIDTH-1:0] FN_AND = 6'h24;
  localparam logic [FUNCT_WIDTH-1:0] FN_OR  = 6'h25;
  localparam logic [FUNCT_WIDTH-1:0] FN_SLT = 6'h2a;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0, // Also the address adder.
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_e;

endpackage

`default_nettype wire

//--- design/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;
  import cpu_isa_pkg::*;

  typedef struct packed {
    logic stall;
    logic flush;
  } stage_ctrl_t;

  typedef struct packed {
    stage_ctrl_t fetch;
    stage_ctrl_t decode;
    stage_ctrl_t exec;
    stage_ctrl_t result;
  } pipe_ctrl_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage register payloads.
  typedef struct packed {
    logic                   valid;
    logic [ADDR_WIDTH-1:0]  pc;
    logic [INSTR_WIDTH-1:0] instr;
  } fetch_pkt_t;

  typedef struct packed {
    logic                      valid;
    logic [ADDR_WIDTH-1:0]     pc;
    logic [REG_ADDR_WIDTH-1:0] rs;
    logic [REG_ADDR_WIDTH-1:0] rt;
    logic [DATA_WIDTH-1:0]     rs_val;
    logic [DATA_WIDTH-1:0]     rt_val;
    logic [DATA_WIDTH-1:0]     imm;    // Sign extended.
    logic [REG_ADDR_WIDTH-1:0] rd;
    alu_op_e                   alu_op;
    logic                      reg_write;
    logic                      mem_read;
    logic                      mem_write;
    logic                      alu_src_imm;
    logic                      branch;
  } decode_pkt_t;

  typedef struct packed {
    logic                      valid;
    logic [ADDR_WIDTH-1:0]     pc;
    logic [DATA_WIDTH-1:0]     alu_result; // Address for loads and stores.
    logic [DATA_WIDTH-1:0]     store_data;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic                      reg_write;
    logic                      mem_read;
    logic                      mem_write;
  } exec_pkt_t;

  typedef struct packed {
    logic                      valid;
    logic [ADDR_WIDTH-1:0]     pc;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [DATA_WIDTH-1:0]     data;
    logic                      reg_write;
  } retire_t;

endpackage

`default_nettype wire

//--- design/pipe_stage_register.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_stage_register
  import cpu_pipe_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  wire         clk,
  input  wire         reset,
  input  stage_ctrl_t ctrl,
  input  payload_t    d,
  output payload_t    q
);

  // All zeros is an invalid entry for every payload.
  always_ff @(posedge clk) begin
    if (reset || ctrl.flush) begin
      q <= '0;
    end else if (!ctrl.stall) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  wire                    clk,
  input  wire                    reset,
  input  stage_ctrl_t            ctrl,
  input  wire                    branch_taken,
  input  wire [ADDR_WIDTH-1:0]   branch_target,
  output logic [ADDR_WIDTH-1:0]  imem_addr,
  input  wire [INSTR_WIDTH-1:0]  imem_data,
  output fetch_pkt_t             fetch_out
);

  logic [ADDR_WIDTH-1:0] pc;
  fetch_pkt_t            fetch_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (!ctrl.stall) begin
      pc <= branch_taken ? branch_target : pc + ADDR_WIDTH'(INSTR_BYTES);
    end
  end

  assign imem_addr = pc; // Instruction comes back in the same cycle.

  always_comb begin
    fetch_d.valid = 1'b1;
    fetch_d.pc    = pc;
    fetch_d.instr = imem_data;
  end

  pipe_stage_register #(.payload_t(fetch_pkt_t)) i_fetch_reg (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .d     (fetch_d),
    .q     (fetch_out)
  );

endmodule

`default_nettype wire

//--- design/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  wire          clk,
  input  wire          reset,
  input  stage_ctrl_t  ctrl,
  input  fetch_pkt_t   fetch_in,
  input  retire_t      wb,
  output logic         load_use,
  output decode_pkt_t  decode_out
);

  logic [OPCODE_WIDTH-1:0]   opcode;
  logic [FUNCT_WIDTH-1:0]    funct;
  logic [REG_ADDR_WIDTH-1:0] rs_idx;
  logic [REG_ADDR_WIDTH-1:0] rt_idx;
  logic [REG_ADDR_WIDTH-1:0] rd_idx;
  logic [IMM_WIDTH-1:0]      imm16;
  logic                      uses_rt;
  logic [DATA_WIDTH-1:0]     regs [NUM_REGS];
  decode_pkt_t               dec;
  decode_pkt_t               held;
  decode_pkt_t               decode_d;
  stage_ctrl_t               reg_ctrl;

  // Register 0 reads zero; a write in flight wins over the stored value.
  function automatic logic [DATA_WIDTH-1:0] bypass(
    input logic [REG_ADDR_WIDTH-1:0] idx,
    input logic [DATA_WIDTH-1:0]     val,
    input retire_t                   w
  );
    if (idx == '0) begin
      return '0;
    end
    if (w.valid && w.reg_write && w.rd == idx) begin
      return w.data;
    end
    return val;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register file.
  always_ff @(posedge clk) begin
    if (wb.valid && wb.reg_write && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field and control decode.
  always_comb begin
    opcode  = fetch_in.instr[OPCODE_LSB +: OPCODE_WIDTH];
    funct   = fetch_in.instr[FUNCT_LSB +: FUNCT_WIDTH];
    rs_idx  = fetch_in.instr[RS_LSB +: REG_ADDR_WIDTH];
    rt_idx  = fetch_in.instr[RT_LSB +: REG_ADDR_WIDTH];
    rd_idx  = fetch_in.instr[RD_LSB +: REG_ADDR_WIDTH];
    imm16   = fetch_in.instr[IMM_LSB +: IMM_WIDTH];
    uses_rt = (opcode == OP_RTYPE) || (opcode == OP_SW) || (opcode == OP_BEQ);

    dec        = '0;
    dec.valid  = fetch_in.valid;
    dec.pc     = fetch_in.pc;
    dec.rs     = rs_idx;
    dec.rt     = rt_idx;
    dec.rs_val = bypass(rs_idx, regs[rs_idx], wb);
    dec.rt_val = bypass(rt_idx, regs[rt_idx], wb);
    dec.imm    = {{(DATA_WIDTH-IMM_WIDTH){imm16[IMM_WIDTH-1]}}, imm16};
    dec.rd     = rt_idx; // I-type destination.
    dec.alu_op = ALU_ADD;

    case (opcode)
      OP_RTYPE: begin
        dec.rd = rd_idx;
        dec.reg_write = 1'b1;
        case (funct)
          FN_ADD:  dec.alu_op = ALU_ADD;
          FN_SUB:  dec.alu_op = ALU_SUB;
          FN_AND:  dec.alu_op = ALU_AND;
          FN_OR:   dec.alu_op = ALU_OR;
          FN_SLT:  dec.alu_op = ALU_SLT;
          default: dec.reg_write = 1'b0; // Unknown funct writes nothing.
        endcase
      end
      OP_ADDI: begin
        dec.reg_write   = 1'b1;
        dec.alu_src_imm = 1'b1;
      end
      OP_LW: begin
        dec.reg_write   = 1'b1;
        dec.mem_read    = 1'b1;
        dec.alu_src_imm = 1'b1;
      end
      OP_SW: begin
        dec.mem_write   = 1'b1;
        dec.alu_src_imm = 1'b1;
      end
      OP_BEQ:  dec.branch = 1'b1;
      default: dec.reg_write = 1'b0;
    endcase
  end

  // Load in execute whose result this instruction needs.
  always_comb begin
    load_use = decode_out.valid && decode_out.mem_read && decode_out.rd != '0 &&
               fetch_in.valid &&
               (decode_out.rd == rs_idx || (uses_rt && decode_out.rd == rt_idx));
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // A held entry picks up retiring writes, since the writeback
  // register empties while the pipe waits on memory.
  always_comb begin
    held        = decode_out;
    held.rs_val = bypass(decode_out.rs, decode_out.rs_val, wb);
    held.rt_val = bypass(decode_out.rt, decode_out.rt_val, wb);
    decode_d    = ctrl.stall ? held : dec;
    reg_ctrl.stall = 1'b0;
    reg_ctrl.flush = ctrl.flush;
  end

  pipe_stage_register #(.payload_t(decode_pkt_t)) i_decode_reg (
    .clk   (clk),
    .reset (reset),
    .ctrl  (reg_ctrl),
    .d     (decode_d),
    .q     (decode_out)
  );

endmodule

`default_nettype wire

//--- design/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  stage_ctrl_t           ctrl,
  input  decode_pkt_t           decode_in,
  input  retire_t               fwd_wb,
  output logic                  branch_taken,
  output logic [ADDR_WIDTH-1:0] branch_target,
  output exec_pkt_t             exec_out
);

  logic [DATA_WIDTH-1:0] rs_fwd;
  logic [DATA_WIDTH-1:0] rt_fwd;
  logic [DATA_WIDTH-1:0] operand_b;
  logic [DATA_WIDTH-1:0] alu_result;
  exec_pkt_t             exec_d;

  // Newest producer first. A load in the exec register has no data yet.
  function automatic logic [DATA_WIDTH-1:0] forward(
    input logic [REG_ADDR_WIDTH-1:0] idx,
    input logic [DATA_WIDTH-1:0]     val
  );
    if (idx == '0) begin
      return '0;
    end
    if (exec_out.valid && exec_out.reg_write && !exec_out.mem_read && exec_out.rd == idx) begin
      return exec_out.alu_result;
    end
    if (fwd_wb.valid && fwd_wb.reg_write && fwd_wb.rd == idx) begin
      return fwd_wb.data;
    end
    return val;
  endfunction

  always_comb begin
    rs_fwd    = forward(decode_in.rs, decode_in.rs_val);
    rt_fwd    = forward(decode_in.rt, decode_in.rt_val);
    operand_b = decode_in.alu_src_imm ? decode_in.imm : rt_fwd;

    case (decode_in.alu_op)
      ALU_ADD: alu_result = rs_fwd + operand_b;
      ALU_SUB: alu_result = rs_fwd - operand_b;
      ALU_AND: alu_result = rs_fwd & operand_b;
      ALU_OR:  alu_result = rs_fwd | operand_b;
      ALU_SLT: alu_result = {{(DATA_WIDTH-1){1'b0}}, $signed(rs_fwd) < $signed(operand_b)};
      default: alu_result = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Branch resolution, no delay slot.
  always_comb begin
    branch_taken  = decode_in.valid && decode_in.branch && (rs_fwd == rt_fwd);
    branch_target = decode_in.pc + ADDR_WIDTH'(INSTR_BYTES) +
                    {decode_in.imm[ADDR_WIDTH-3:0], 2'b00}; // Word offset.
  end

  always_comb begin
    exec_d.valid      = decode_in.valid;
    exec_d.pc         = decode_in.pc;
    exec_d.alu_result = alu_result;
    exec_d.store_data = rt_fwd;
    exec_d.rd         = decode_in.rd;
    exec_d.reg_write  = decode_in.reg_write;
    exec_d.mem_read   = decode_in.mem_read;
    exec_d.mem_write  = decode_in.mem_write;
  end

  pipe_stage_register #(.payload_t(exec_pkt_t)) i_exec_reg (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .d     (exec_d),
    .q     (exec_out)
  );

endmodule

`default_nettype wire

//--- design/result_stage.sv
`timescale 1ns/1ns
`default_nettype none

module result_stage
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  stage_ctrl_t           ctrl,
  input  exec_pkt_t             exec_in,
  output logic                  mem_busy,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [ADDR_WIDTH-1:0] wb_adr,
  output logic [DATA_WIDTH-1:0] wb_dat_o,
  output logic [SEL_WIDTH-1:0]  wb_sel,
  input  wire  [DATA_WIDTH-1:0] wb_dat_i,
  input  wire                   wb_ack,
  output retire_t               retire
);

  logic    mem_req;
  logic    ack_q;
  retire_t retire_d;

  // Keeps cyc low for one cycle after an ack, even when the next
  // access is already waiting.
  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_cyc && wb_ack;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Wishbone classic master.
  always_comb begin
    mem_req  = exec_in.valid && (exec_in.mem_read || exec_in.mem_write);
    wb_cyc   = mem_req && !ack_q;
    wb_stb   = wb_cyc;
    wb_we    = exec_in.mem_write;
    wb_adr   = exec_in.alu_result;
    wb_dat_o = exec_in.store_data; // Held by the exec register stall.
    wb_sel   = '1;
    mem_busy = mem_req && !(wb_cyc && wb_ack);
  end

  always_comb begin
    retire_d.valid     = exec_in.valid;
    retire_d.pc        = exec_in.pc;
    retire_d.rd        = exec_in.rd;
    retire_d.data      = exec_in.mem_read ? wb_dat_i : exec_in.alu_result;
    retire_d.reg_write = exec_in.reg_write;
  end

  pipe_stage_register #(.payload_t(retire_t)) i_wb_reg (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .d     (retire_d),
    .q     (retire)
  );

endmodule

`default_nettype wire

//--- design/pipeline_control.sv
`timescale 1ns/1ns
`default_nettype none

module pipeline_control
  import cpu_pipe_pkg::*;
(
  input  wire        load_use,
  input  wire        branch_taken,
  input  wire        mem_busy,
  output pipe_ctrl_t ctrl
);

  always_comb begin
    ctrl = '0;
    if (mem_busy) begin
      ctrl.fetch.stall  = 1'b1;
      ctrl.decode.stall = 1'b1;
      ctrl.exec.stall   = 1'b1;
      ctrl.result.flush = 1'b1; // Bubble into writeback.
    end else if (branch_taken) begin
      ctrl.fetch.flush  = 1'b1;
      ctrl.decode.flush = 1'b1;
    end else if (load_use) begin
      ctrl.fetch.stall  = 1'b1;
      ctrl.decode.flush = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/pipeline_core.sv
`timescale 1ns/1ns
`default_nettype none

module pipeline_core
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  wire                    clk,
  input  wire                    reset,
  output logic [ADDR_WIDTH-1:0]  imem_addr,
  input  wire  [INSTR_WIDTH-1:0] imem_data,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [ADDR_WIDTH-1:0]  wb_adr,
  output logic [DATA_WIDTH-1:0]  wb_dat_o,
  output logic [SEL_WIDTH-1:0]   wb_sel,
  input  wire  [DATA_WIDTH-1:0]  wb_dat_i,
  input  wire                    wb_ack,
  output retire_t                retire
);

  pipe_ctrl_t            pipe_ctrl;
  fetch_pkt_t            fetch_pkt;
  decode_pkt_t           decode_pkt;
  exec_pkt_t             exec_pkt;
  logic                  load_use;
  logic                  branch_taken;
  logic [ADDR_WIDTH-1:0] branch_target;
  logic                  mem_busy;

  fetch_unit i_fetch (
    .clk           (clk),
    .reset         (reset),
    .ctrl          (pipe_ctrl.fetch),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .imem_addr     (imem_addr),
    .imem_data     (imem_data),
    .fetch_out     (fetch_pkt)
  );

  instr_decode i_decode (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (pipe_ctrl.decode),
    .fetch_in   (fetch_pkt),
    .wb         (retire),
    .load_use   (load_use),
    .decode_out (decode_pkt)
  );

  execute_unit i_execute (
    .clk           (clk),
    .reset         (reset),
    .ctrl          (pipe_ctrl.exec),
    .decode_in     (decode_pkt),
    .fwd_wb        (retire),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .exec_out      (exec_pkt)
  );

  result_stage i_result (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (pipe_ctrl.result),
    .exec_in  (exec_pkt),
    .mem_busy (mem_busy),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat_o),
    .wb_sel   (wb_sel),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack),
    .retire   (retire)
  );

  pipeline_control i_control (
    .load_use     (load_use),
    .branch_taken (branch_taken),
    .mem_busy     (mem_busy),
    .ctrl         (pipe_ctrl)
  );

endmodule

`default_nettype wire

//--- verif/core_assert.sv
`timescale 1ns/1ns
`default_nettype none

module core_assert
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input wire                  clk,
  input wire                  reset,
  input wire                  wb_cyc,
  input wire                  wb_stb,
  input wire                  wb_we,
  input wire [ADDR_WIDTH-1:0] wb_adr,
  input wire [DATA_WIDTH-1:0] wb_dat_o,
  input wire                  wb_ack,
  input retire_t              retire
);

  int failure_count = 0; // Read by the testbench at the end.

  a_stb_in_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_stb |-> wb_cyc)
    else begin
      $error("wb_stb high without wb_cyc");
      failure_count++;
    end

  // Request held until the slave acks.
  a_request_stable: assert property (@(posedge clk) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o))
    else begin
      $error("Wishbone request changed before ack");
      failure_count++;
    end

  a_ack_with_stb: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> wb_stb)
    else begin
      $error("wb_ack high without wb_stb");
      failure_count++;
    end

  a_retire_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(retire.valid))
    else begin
      $error("retire.valid is unknown");
      failure_count++;
    end

endmodule

bind pipeline_core core_assert i_core_assert (
  .clk      (clk),
  .reset    (reset),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_we    (wb_we),
  .wb_adr   (wb_adr),
  .wb_dat_o (wb_dat_o),
  .wb_ack   (wb_ack),
  .retire   (retire)
);

`default_nettype wire

//--- verif/core_checker.sv
`timescale 1ns/1ns
`default_nettype none

module core_checker
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  retire_t               retire,
  input  wire                   wb_cyc,
  input  wire                   wb_stb,
  input  wire                   wb_we,
  input  wire  [ADDR_WIDTH-1:0] wb_adr,
  input  wire  [DATA_WIDTH-1:0] wb_dat_o,
  input  wire  [SEL_WIDTH-1:0]  wb_sel,
  input  wire                   wb_ack,
  output int                    retires_seen,
  output int                    stores_seen,
  output int                    retire_errors,
  output int                    store_errors
);

  retire_t               exp_retire      [$];
  int                    exp_retire_test [$];
  logic [ADDR_WIDTH-1:0] exp_store_addr  [$];
  logic [DATA_WIDTH-1:0] exp_store_data  [$];
  int                    exp_store_test  [$];

  initial begin
    retires_seen  = 0;
    stores_seen   = 0;
    retire_errors = 0;
    store_errors  = 0;
  end

  function automatic string test_name(input int id);
    case (id)
      1:       return "alu_immediate";
      2:       return "forwarding";
      3:       return "load_use";
      4:       return "memory_wait";
      5:       return "branch";
      6:       return "register_zero";
      default: return "unknown";
    endcase
  endfunction

  // Prints the mismatch and returns one when the values differ.
  function automatic bit differs(input string name, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
    if (act === exp) begin
      return 1'b0;
    end
    $display("error %s: %s expected %h actual %h", name, field, exp, act);
    return 1'b1;
  endfunction

  task automatic expect_retire(input int test_id, input retire_t rec);
    exp_retire.push_back(rec);
    exp_retire_test.push_back(test_id);
  endtask

  task automatic add_store(input int test_id, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] data);
    exp_store_addr.push_back(addr);
    exp_store_data.push_back(data);
    exp_store_test.push_back(test_id);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // In-order comparison.
  task automatic check_retire();
    retire_t exp;
    string   name;
    exp  = exp_retire[retires_seen];
    name = test_name(exp_retire_test[retires_seen]);
    retire_errors += differs(name, "retire pc", exp.pc, retire.pc);
    retire_errors += differs(name, "retire reg_write", exp.reg_write, retire.reg_write);
    if (exp.reg_write) begin // Data only means something when written.
      retire_errors += differs(name, "retire rd", exp.rd, retire.rd);
      retire_errors += differs(name, "retire data", exp.data, retire.data);
    end
    retires_seen++;
  endtask

  task automatic check_store();
    string name;
    if (stores_seen >= exp_store_addr.size()) begin
      $display("unexpected store of %h to address %h", wb_dat_o, wb_adr);
      store_errors++;
    end else begin
      name = test_name(exp_store_test[stores_seen]);
      store_errors += differs(name, "store address", exp_store_addr[stores_seen], wb_adr);
      store_errors += differs(name, "store data", exp_store_data[stores_seen], wb_dat_o);
      stores_seen++;
    end
  endtask

  always @(posedge clk) begin
    if (!reset) begin
      if (retire.valid && retires_seen < exp_retire.size()) begin
        check_retire();
      end
      if (wb_cyc && wb_stb && wb_ack) begin // Every access selects all bytes.
        store_errors += differs(test_name(4), "wb_sel", {SEL_WIDTH{1'b1}}, wb_sel);
      end
      if (wb_cyc && wb_stb && wb_we && wb_ack) begin
        check_store();
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
();

  localparam int CLK_PERIOD   = 4;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 3;
  localparam int DONE_TIMEOUT = 1000; // Cycles for the whole program.
  localparam int ROM_WORDS    = 256;
  localparam int DMEM_WORDS   = 64;
  localparam int REC_WORDS    = 6;
  localparam int VEC_WORDS    = REC_WORDS * 64;
  localparam int KIND_PROGRAM = 1;
  localparam int KIND_RETIRE  = 2;
  localparam int KIND_STORE   = 3;
  localparam int unsigned SEED = 25115;

  logic                   clk;
  logic                   reset;
  logic [ADDR_WIDTH-1:0]  imem_addr;
  logic [INSTR_WIDTH-1:0] imem_data;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [ADDR_WIDTH-1:0]  wb_adr;
  logic [DATA_WIDTH-1:0]  wb_dat_o;
  logic [SEL_WIDTH-1:0]   wb_sel;
  logic [DATA_WIDTH-1:0]  wb_dat_i;
  logic                   wb_ack;
  retire_t                retire;

  int retires_seen;
  int stores_seen;
  int retire_errors;
  int store_errors;
  int other_errors;
  int n_retire;
  int n_store;
  int prog_len;

  logic [31:0]            vec_mem  [VEC_WORDS];
  logic [INSTR_WIDTH-1:0] rom      [ROM_WORDS];
  logic [DATA_WIDTH-1:0]  data_mem [DMEM_WORDS];
  int unsigned            lcg_state = SEED;

  pipeline_core i_dut (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_o  (wb_dat_o),
    .wb_sel    (wb_sel),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack),
    .retire    (retire)
  );

  core_checker i_checker (
    .clk           (clk),
    .reset         (reset),
    .retire        (retire),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_o      (wb_dat_o),
    .wb_sel        (wb_sel),
    .wb_ack        (wb_ack),
    .retires_seen  (retires_seen),
    .stores_seen   (stores_seen),
    .retire_errors (retire_errors),
    .store_errors  (store_errors)
  );

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Combinational ROM, zero past the program.
  assign imem_data = (imem_addr < 4 * ROM_WORDS) ? rom[imem_addr[9:2]] : '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Vector file: program words, retire and store expectations.
  task automatic load_vectors();
    int      i;
    retire_t rec;
    for (i = 0; i < VEC_WORDS; i++) begin
      vec_mem[i] = '0;
    end
    for (i = 0; i < ROM_WORDS; i++) begin
      rom[i] = '0;
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
      data_mem[i] = 32'h5a5a_0000 ^ (i << 2); // Pattern from the byte address.
    end
    prog_len = 0;
    n_retire = 0;
    n_store  = 0;
    $readmemh("verif/core_vectors.txt", vec_mem);
    for (i = 0; i < VEC_WORDS; i += REC_WORDS) begin
      case (vec_mem[i])
        KIND_PROGRAM: begin
          if (prog_len < ROM_WORDS) begin
            rom[prog_len] = vec_mem[i+2];
          end
          prog_len++;
        end
        KIND_RETIRE: begin
          rec.valid     = 1'b1;
          rec.pc        = vec_mem[i+2];
          rec.rd        = vec_mem[i+3][REG_ADDR_WIDTH-1:0];
          rec.data      = vec_mem[i+4];
          rec.reg_write = vec_mem[i+5][0];
          i_checker.expect_retire(vec_mem[i+1], rec);
          n_retire++;
        end
        KIND_STORE: begin
          i_checker.add_store(vec_mem[i+1], vec_mem[i+2], vec_mem[i+3]);
          n_store++;
        end
        default: begin
        end
      endcase
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Wishbone slave memory with 0 to 3 wait cycles.
  initial begin : wb_slave
    int unsigned waits_left;
    logic        in_access;
    wb_ack     = 1'b0;
    wb_dat_i   = '0;
    in_access  = 1'b0;
    waits_left = 0;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (reset || wb_ack) begin
        wb_ack    = 1'b0; // Ack lasts one cycle.
        in_access = 1'b0;
      end else if (wb_cyc && wb_stb) begin
        if (!in_access) begin
          in_access  = 1'b1;
          waits_left = (next_random() >> 16) % 4;
        end
        if (waits_left == 0) begin
          if (wb_we) begin
            data_mem[wb_adr[7:2]] = wb_dat_o;
          end else begin
            wb_dat_i = data_mem[wb_adr[7:2]];
          end
          wb_ack = 1'b1;
        end else begin
          waits_left--;
        end
      end
    end
  end

  initial begin : main
    int cycles;
    reset        = 1'b1;
    other_errors = 0;
    load_vectors();
    if (prog_len == 0) begin
      $display("no program words found in the vector file");
      other_errors++;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset  = 1'b0;
    cycles = 0;
    while ((retires_seen < n_retire || stores_seen < n_store) && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (retires_seen < n_retire || stores_seen < n_store) begin
      $display("timeout after %0d cycles, %0d of %0d retires and %0d of %0d stores seen",
               cycles, retires_seen, n_retire, stores_seen, n_store);
      other_errors++;
    end
    other_errors += i_dut.i_core_assert.failure_count; // Protocol assertion failures.
    $display("retire errors %0d, store errors %0d, other errors %0d",
             retire_errors, store_errors, other_errors);
    if (retire_errors + store_errors + other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/core_vectors.txt
// Columns in hex: kind test a b c d. Kind 1 program word a. Kind 2 retire pc a, rd b,
// data c, reg_write d. Kind 3 store address a, data b. Test ids name behaviors 1 to 6.
1 0 20010005 0 0 0
1 0 2002000e 0 0 0
1 0 00221820 0 0 0
1 0 00612022 0 0 0
1 0 00622824 0 0 0
1 0 00a13025 0 0 0
1 0 2007fffd 0 0 0
1 0 00e6402a 0 0 0
1 0 ac030040 0 0 0
1 0 ad060043 0 0 0
1 0 8c090040 0 0 0
1 0 01295020 0 0 0
1 0 8c0b0044 0 0 0
1 0 11660002 0 0 0
1 0 200c0001 0 0 0
1 0 200d0001 0 0 0
1 0 20000009 0 0 0
1 0 00017020 0 0 0
1 0 10220005 0 0 0
1 0 21cfffff 0 0 0
2 1 00000000 01 00000005 1
2 1 00000004 02 0000000e 1
2 2 00000008 03 00000013 1
2 2 0000000c 04 0000000e 1
2 2 00000010 05 00000002 1
2 2 00000014 06 00000007 1
2 1 00000018 07 fffffffd 1
2 2 0000001c 08 00000001 1
2 4 00000020 00 00000000 0
2 4 00000024 00 00000000 0
2 4 00000028 09 00000013 1
2 3 0000002c 0a 00000026 1
2 4 00000030 0b 00000007 1
2 5 00000034 00 00000000 0
2 6 00000040 00 00000009 1
2 6 00000044 0e 00000005 1
2 5 00000048 00 00000000 0
2 5 0000004c 0f 00000004 1
3 4 00000040 00000013 0 0
3 4 00000044 00000007 0 0

//--- verilog.f
design/cpu_isa_pkg.sv
design/cpu_pipe_pkg.sv
design/pipe_stage_register.sv
design/fetch_unit.sv
design/instr_decode.sv
design/execute_unit.sv
design/result_stage.sv
design/pipeline_control.sv
design/pipeline_core.sv
verif/core_assert.sv
verif/core_checker.sv
verif/core_tb.sv
